// ==== include/core_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core build settings
// Reset address, trap behaviour, register file size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// First instruction fetch after rst_n releases
`define CORE_RESET_ADDR 32'h0000_0000

// Integer registers, x0 included and tied to zero
`define CORE_NUM_REGS 32

// Trap behaviour is fixed. Any trap parks the sequencer in HALT
// with the cause held on trap_cause until the next reset, and no
// further bus cycle is started.

`endif

// ==== hdl/isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I encodings: opcodes, funct3 codes,
// ALU operations, immediate formats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

  // Major opcodes the core accepts
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,  // ADD/SUB
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,  // SRL/SRA by bit 30
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  localparam logic [2:0] F3_WORD = 3'b010;  // Only LW/SW width

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

endpackage

// ==== hdl/ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control types: sequencer states,
// datapath selects, trap causes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrl_pkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEM,
    ST_WRITEBACK,
    ST_HALT
  } state_e;

  typedef enum logic [1:0] {
    SRC_A_RS1,
    SRC_A_PC,
    SRC_A_OLD_PC  // PC of the instruction in IR
  } src_a_e;

  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_LOAD,
    RES_PC4  // Link value, PC register already advanced
  } result_e;

  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_ILLEGAL,
    TRAP_MISALIGNED,
    TRAP_BUS_ERR
  } trap_cause_e;

endpackage

// ==== hdl/control_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multicycle sequencer and decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module control_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [31:0]               instr,
  input  logic                      alu_zero,
  input  logic                      alu_lt,
  input  logic                      addr_misaligned,
  input  logic                      mem_done,
  input  logic                      mem_err,
  output logic                      pc_write,
  output logic                      old_pc_write,
  output logic                      ir_write,
  output logic                      reg_write,
  output logic                      alu_out_write,
  output isa_pkg::alu_op_e          alu_op,
  output isa_pkg::imm_fmt_e         imm_fmt,
  output ctrl_pkg::src_a_e          src_a,
  output ctrl_pkg::src_b_e          src_b,
  output ctrl_pkg::result_e         result_sel,
  output logic                      mem_req,
  output logic                      mem_we,
  output logic                      instr_retired,
  output logic                      trap,
  output ctrl_pkg::trap_cause_e     trap_cause
);

  ctrl_pkg::state_e      state_q, state_d;
  ctrl_pkg::trap_cause_e cause_q, cause_d;
  isa_pkg::opcode_e      opcode;
  isa_pkg::alu_op_e      arith_op, cmp_op;
  logic [2:0]            funct3;
  logic                  take, take_q;
  logic                  busy_q;  // Request issued, waiting for done/err

  function automatic isa_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                 input logic reg_op);
    isa_pkg::alu_op_e op;
    case (isa_pkg::alu_f3_e'(f3))
      isa_pkg::F3_ADD:  op = (alt && reg_op) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  op = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  op = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: op = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SR:   op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
      default:          op = isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  function automatic logic is_legal(input logic [31:0] word);
    logic ok;
    case (isa_pkg::opcode_e'(word[6:0]))
      isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC, isa_pkg::OPC_JAL,
      isa_pkg::OPC_OP_IMM, isa_pkg::OPC_OP:    ok = 1'b1;
      isa_pkg::OPC_JALR:                       ok = (word[14:12] == 3'b000);
      isa_pkg::OPC_BRANCH:                     ok = (word[14:13] != 2'b01);
      isa_pkg::OPC_LOAD, isa_pkg::OPC_STORE:   ok = (word[14:12] == isa_pkg::F3_WORD);
      default:                                 ok = 1'b0;
    endcase
    return ok;
  endfunction

  assign opcode   = isa_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign arith_op = alu_decode(funct3, instr[30], opcode == isa_pkg::OPC_OP);
  // EQ/NE compare by subtraction, the others by set-less-than
  assign cmp_op   = !funct3[2] ? isa_pkg::ALU_SUB :
                    (funct3[1] ? isa_pkg::ALU_SLTU : isa_pkg::ALU_SLT);

  always_comb begin
    case (isa_pkg::branch_e'(funct3))
      isa_pkg::BR_BEQ:                   take = alu_zero;
      isa_pkg::BR_BNE:                   take = !alu_zero;
      isa_pkg::BR_BLT, isa_pkg::BR_BLTU: take = alu_lt;
      default:                           take = !alu_lt;  // BGE, BGEU
    endcase
  end

  // One-cycle pulse on the first cycle of FETCH or MEM
  assign mem_req    = ((state_q == ctrl_pkg::ST_FETCH) || (state_q == ctrl_pkg::ST_MEM)) &&
                      !busy_q;
  assign trap       = (state_q == ctrl_pkg::ST_HALT);
  assign trap_cause = cause_q;

  always_comb begin
    state_d       = state_q;
    cause_d       = cause_q;
    pc_write      = 1'b0;
    old_pc_write  = 1'b0;
    ir_write      = 1'b0;
    reg_write     = 1'b0;
    alu_out_write = 1'b0;
    alu_op        = isa_pkg::ALU_ADD;
    imm_fmt       = isa_pkg::IMM_I;
    src_a         = ctrl_pkg::SRC_A_RS1;
    src_b         = ctrl_pkg::SRC_B_RS2;
    result_sel    = ctrl_pkg::RES_ALU;
    mem_we        = 1'b0;
    instr_retired = 1'b0;
    case (state_q)
      ctrl_pkg::ST_FETCH: begin
        ir_write = 1'b1;  // Held all of FETCH, steers mem_addr to PC
        src_a    = ctrl_pkg::SRC_A_PC;
        src_b    = ctrl_pkg::SRC_B_FOUR;
        if (mem_err) begin
          state_d = ctrl_pkg::ST_HALT;
          cause_d = ctrl_pkg::TRAP_BUS_ERR;
        end else if (mem_done) begin
          pc_write     = 1'b1;
          old_pc_write = 1'b1;
          state_d      = ctrl_pkg::ST_DECODE;
        end
      end
      ctrl_pkg::ST_DECODE: begin
        if (is_legal(instr)) begin
          state_d = ctrl_pkg::ST_EXECUTE;
        end else begin
          state_d = ctrl_pkg::ST_HALT;
          cause_d = ctrl_pkg::TRAP_ILLEGAL;
        end
      end
      ctrl_pkg::ST_EXECUTE: begin
        alu_out_write = 1'b1;
        state_d       = ctrl_pkg::ST_WRITEBACK;
        case (opcode)
          isa_pkg::OPC_OP:     alu_op = arith_op;
          isa_pkg::OPC_OP_IMM: begin
            src_b  = ctrl_pkg::SRC_B_IMM;
            alu_op = arith_op;
          end
          isa_pkg::OPC_LUI: begin
            src_b   = ctrl_pkg::SRC_B_IMM;
            imm_fmt = isa_pkg::IMM_U;
            alu_op  = isa_pkg::ALU_PASS_B;
          end
          isa_pkg::OPC_AUIPC: begin
            src_a   = ctrl_pkg::SRC_A_OLD_PC;
            src_b   = ctrl_pkg::SRC_B_IMM;
            imm_fmt = isa_pkg::IMM_U;
          end
          isa_pkg::OPC_JAL, isa_pkg::OPC_JALR: begin
            // Link and jump share this edge, PC still holds old PC + 4
            src_a = (opcode == isa_pkg::OPC_JAL) ? ctrl_pkg::SRC_A_OLD_PC :
                                                   ctrl_pkg::SRC_A_RS1;
            src_b         = ctrl_pkg::SRC_B_IMM;
            imm_fmt       = (opcode == isa_pkg::OPC_JAL) ? isa_pkg::IMM_J : isa_pkg::IMM_I;
            pc_write      = 1'b1;
            reg_write     = 1'b1;
            result_sel    = ctrl_pkg::RES_PC4;
            instr_retired = 1'b1;
            state_d       = ctrl_pkg::ST_FETCH;
          end
          isa_pkg::OPC_BRANCH: alu_op = cmp_op;
          default: begin  // LW or SW, decode let nothing else through
            src_b   = ctrl_pkg::SRC_B_IMM;
            imm_fmt = (opcode == isa_pkg::OPC_STORE) ? isa_pkg::IMM_S : isa_pkg::IMM_I;
            if (addr_misaligned) begin
              state_d = ctrl_pkg::ST_HALT;
              cause_d = ctrl_pkg::TRAP_MISALIGNED;
            end else begin
              state_d = ctrl_pkg::ST_MEM;
            end
          end
        endcase
      end
      ctrl_pkg::ST_MEM: begin
        mem_we = (opcode == isa_pkg::OPC_STORE);
        if (mem_err) begin
          state_d = ctrl_pkg::ST_HALT;
          cause_d = ctrl_pkg::TRAP_BUS_ERR;
        end else if (mem_done) begin
          instr_retired = mem_we;  // A store ends here
          state_d       = mem_we ? ctrl_pkg::ST_FETCH : ctrl_pkg::ST_WRITEBACK;
        end
      end
      ctrl_pkg::ST_WRITEBACK: begin
        instr_retired = 1'b1;
        state_d       = ctrl_pkg::ST_FETCH;
        case (opcode)
          isa_pkg::OPC_BRANCH: begin
            src_a    = ctrl_pkg::SRC_A_OLD_PC;
            src_b    = ctrl_pkg::SRC_B_IMM;
            imm_fmt  = isa_pkg::IMM_B;
            pc_write = take_q;
          end
          isa_pkg::OPC_LOAD: begin
            reg_write  = 1'b1;
            result_sel = ctrl_pkg::RES_LOAD;
          end
          default: reg_write = 1'b1;
        endcase
      end
      default: ;  // HALT until reset
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::ST_FETCH;
      cause_q <= ctrl_pkg::TRAP_NONE;
      take_q  <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cause_q <= cause_d;
      if (state_q == ctrl_pkg::ST_EXECUTE) take_q <= take;  // Branch outcome for WRITEBACK
      if (mem_req) begin
        busy_q <= 1'b1;
      end else if (mem_done || mem_err) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/datapath_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC, IR, register file, immediates,
// ALU and result selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "core_settings.svh"

module datapath_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_write,
  input  logic                  old_pc_write,
  input  logic                  ir_write,
  input  logic                  reg_write,
  input  logic                  alu_out_write,
  input  isa_pkg::alu_op_e      alu_op,
  input  isa_pkg::imm_fmt_e     imm_fmt,
  input  ctrl_pkg::src_a_e      src_a,
  input  ctrl_pkg::src_b_e      src_b,
  input  ctrl_pkg::result_e     result_sel,
  input  logic [31:0]           mem_rdata,
  input  logic                  mem_done,
  output logic [31:0]           instr,
  output logic [31:0]           pc,
  output logic [31:0]           mem_addr,
  output logic [31:0]           mem_wdata,
  output logic                  alu_zero,
  output logic                  alu_lt,
  output logic                  addr_misaligned
);

  logic [31:0] pc_q, old_pc_q, ir_q;
  logic [31:0] alu_out_q, load_q;
  logic [31:0] regs [0:`CORE_NUM_REGS-1];
  logic [4:0]  rs1_idx, rs2_idx, rd_idx;
  logic [31:0] rs1_val, rs2_val;
  logic [31:0] imm, op_a, op_b, alu_result, result;
  logic [4:0]  shamt;

  assign rs1_idx = ir_q[19:15];
  assign rs2_idx = ir_q[24:20];
  assign rd_idx  = ir_q[11:7];

  // x0 reads as zero, its storage is never written
  assign rs1_val = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

  always_comb begin
    case (imm_fmt)
      isa_pkg::IMM_S: imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
      isa_pkg::IMM_B: imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
      isa_pkg::IMM_U: imm = {ir_q[31:12], 12'd0};
      isa_pkg::IMM_J: imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
      default:        imm = {{20{ir_q[31]}}, ir_q[31:20]};
    endcase
  end

  always_comb begin
    case (src_a)
      ctrl_pkg::SRC_A_PC:     op_a = pc_q;
      ctrl_pkg::SRC_A_OLD_PC: op_a = old_pc_q;
      default:                op_a = rs1_val;
    endcase
    case (src_b)
      ctrl_pkg::SRC_B_IMM:  op_b = imm;
      ctrl_pkg::SRC_B_FOUR: op_b = 32'd4;
      default:              op_b = rs2_val;
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      isa_pkg::ALU_SUB:    alu_result = op_a - op_b;
      isa_pkg::ALU_SLL:    alu_result = op_a << shamt;
      isa_pkg::ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      isa_pkg::ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
      isa_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      isa_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      isa_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      isa_pkg::ALU_OR:     alu_result = op_a | op_b;
      isa_pkg::ALU_AND:    alu_result = op_a & op_b;
      isa_pkg::ALU_PASS_B: alu_result = op_b;
      default:             alu_result = op_a + op_b;
    endcase
  end

  assign alu_zero        = (alu_result == 32'd0);
  assign alu_lt          = (alu_op == isa_pkg::ALU_SLTU) ? (op_a < op_b) :
                                                           ($signed(op_a) < $signed(op_b));
  assign addr_misaligned = |alu_result[1:0];  // Word accesses only

  always_comb begin
    case (result_sel)
      ctrl_pkg::RES_LOAD: result = load_q;
      ctrl_pkg::RES_PC4:  result = pc_q;
      default:            result = alu_out_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `CORE_RESET_ADDR;
    end else if (pc_write) begin
      pc_q <= {alu_result[31:1], 1'b0};  // JALR clears bit 0
    end
  end

  always_ff @(posedge clk) begin
    if (old_pc_write) old_pc_q <= pc_q;
    if (ir_write && mem_done) ir_q <= mem_rdata;
    if (!ir_write && mem_done) load_q <= mem_rdata;  // Data phase completion
    if (alu_out_write) alu_out_q <= alu_result;
    if (reg_write && (rd_idx != 5'd0)) regs[rd_idx] <= result;
  end

  // ir_write is high for the whole fetch, so it doubles as the fetch flag
  assign mem_addr  = ir_write ? pc_q : alu_out_q;
  assign mem_wdata = rs2_val;
  assign instr     = ir_q;
  assign pc        = pc_q;

endmodule

// ==== hdl/wb_bus_bridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core request port to Wishbone classic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module wb_bus_bridge (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_req,
  input  logic        mem_we,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  output logic        mem_done,
  output logic        mem_err,
  output logic [31:0] mem_rdata,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [3:0]  wb_sel,
  output logic [31:0] wb_wdata,
  input  logic [31:0] wb_rdata,
  input  logic        wb_ack,
  input  logic        wb_err
);

  logic cyc_q, we_q, done_q, err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q  <= 1'b0;
      we_q   <= 1'b0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      if (cyc_q) begin
        if (wb_ack || wb_err) begin  // Ack wins if both
          cyc_q  <= 1'b0;
          we_q   <= 1'b0;
          done_q <= wb_ack;
          err_q  <= !wb_ack;
        end
      end else if (mem_req) begin
        cyc_q <= 1'b1;
        we_q  <= mem_we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!cyc_q && mem_req) begin
      wb_adr   <= mem_addr;
      wb_wdata <= mem_wdata;
    end
    if (cyc_q && wb_ack) mem_rdata <= wb_rdata;
  end

  assign wb_cyc   = cyc_q;
  assign wb_stb   = cyc_q;
  assign wb_we    = we_q;
  assign wb_sel   = 4'hf;  // Word accesses only
  assign mem_done = done_q;
  assign mem_err  = err_q;

endmodule

// ==== hdl/rv_mc_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multicycle RV32I core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rv_mc_core (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [31:0]           wb_adr,
  output logic [3:0]            wb_sel,
  output logic [31:0]           wb_wdata,
  input  logic [31:0]           wb_rdata,
  input  logic                  wb_ack,
  input  logic                  wb_err,
  output logic [31:0]           pc,
  output logic                  instr_retired,
  output logic                  trap,
  output ctrl_pkg::trap_cause_e trap_cause
);

  logic [31:0]        instr;
  logic               alu_zero, alu_lt, addr_misaligned;
  logic               pc_write, old_pc_write, ir_write, reg_write, alu_out_write;
  isa_pkg::alu_op_e   alu_op;
  isa_pkg::imm_fmt_e  imm_fmt;
  ctrl_pkg::src_a_e   src_a;
  ctrl_pkg::src_b_e   src_b;
  ctrl_pkg::result_e  result_sel;

  // Internal memory port between the three blocks
  logic               mem_req, mem_we, mem_done, mem_err;
  logic [31:0]        mem_addr, mem_wdata, mem_rdata;

  // Port names match the nets above one to one
  control_unit control_unit_i (.*);

  datapath_unit datapath_unit_i (.*);

  wb_bus_bridge wb_bus_bridge_i (.*);

endmodule

// ==== bench/clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
  end

  always #4 clk = ~clk;  // 8 ns period

  // Two cycles low, edges placed just after the clock
  task automatic apply_reset();
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

endmodule

// ==== bench/wb_memory_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave memory
// Random wait states, error window, test programs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module wb_memory_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [1:0]  prog_sel,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  input  logic [3:0]  wb_sel,
  input  logic [31:0] wb_wdata,
  output logic [31:0] wb_rdata,
  output logic        wb_ack,
  output logic        wb_err
);

  logic [31:0] mem [0:1023];
  logic [1:0]  wait_cnt;
  logic        pending;
  int          pc_idx;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, isa_pkg::F3_WORD, imm[4:0], isa_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return enc_i(imm, rs1, isa_pkg::F3_ADD, rd, isa_pkg::OPC_OP_IMM);
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[pc_idx] = word;
    pc_idx++;
  endtask

  // Main program of arithmetic, control flow and load/store
  task automatic load_main();
    emit(addi(5'd20, 5'd0, 12'h400));  // Result area base
    emit(addi(5'd1, 5'd0, 12'd100));
    emit(addi(5'd2, 5'd0, 12'hff9));  // -7
    emit(enc_u(20'h12345, 5'd3, isa_pkg::OPC_LUI));
    emit(enc_u(20'h00001, 5'd4, isa_pkg::OPC_AUIPC));
    emit(enc_i(12'd4, 5'd2, isa_pkg::F3_SLL, 5'd5, isa_pkg::OPC_OP_IMM));
    emit(enc_i(12'h401, 5'd2, isa_pkg::F3_SR, 5'd6, isa_pkg::OPC_OP_IMM));  // SRAI
    emit(enc_i(12'd28, 5'd2, isa_pkg::F3_SR, 5'd7, isa_pkg::OPC_OP_IMM));
    emit(enc_r(7'h00, 5'd1, 5'd2, isa_pkg::F3_SLT, 5'd8));
    emit(enc_r(7'h00, 5'd1, 5'd2, isa_pkg::F3_SLTU, 5'd9));
    emit(enc_r(7'h00, 5'd2, 5'd1, isa_pkg::F3_XOR, 5'd10));
    emit(enc_r(7'h00, 5'd1, 5'd3, isa_pkg::F3_OR, 5'd11));
    emit(enc_r(7'h00, 5'd1, 5'd2, isa_pkg::F3_AND, 5'd12));
    emit(enc_r(7'h20, 5'd2, 5'd1, isa_pkg::F3_ADD, 5'd13));  // SUB
    for (int k = 1; k <= 13; k++) emit(enc_s(12'(4 * (k - 1)), 5'(k), 5'd20));
    emit(addi(5'd14, 5'd0, 12'd0));
    emit(addi(5'd15, 5'd0, 12'd5));  // Loop bound
    emit(addi(5'd14, 5'd14, 12'd1));
    emit(enc_b(13'h1ffc, 5'd15, 5'd14, isa_pkg::BR_BNE));
    emit(enc_b(13'd8, 5'd15, 5'd14, isa_pkg::BR_BLT));  // Not taken
    emit(enc_b(13'd8, 5'd15, 5'd14, isa_pkg::BR_BGEU));  // Taken
    emit(addi(5'd14, 5'd14, 12'd100));
    emit(enc_j(21'd8, 5'd16));
    emit(addi(5'd14, 5'd14, 12'd100));
    emit(enc_i(12'd12, 5'd16, 3'b000, 5'd17, isa_pkg::OPC_JALR));
    emit(addi(5'd14, 5'd14, 12'd100));
    emit(enc_s(12'd52, 5'd14, 5'd20));
    emit(enc_s(12'd56, 5'd16, 5'd20));
    emit(enc_s(12'd60, 5'd17, 5'd20));
    emit(enc_u(20'ha5a5a, 5'd18, isa_pkg::OPC_LUI));
    emit(addi(5'd18, 5'd18, 12'h5a5));
    emit(enc_s(12'd64, 5'd18, 5'd20));
    emit(enc_i(12'd64, 5'd20, isa_pkg::F3_WORD, 5'd19, isa_pkg::OPC_LOAD));
    emit(enc_s(12'd68, 5'd19, 5'd20));  // Final store
    emit(enc_j(21'd0, 5'd0));  // Spin
  endtask

  task automatic load_program();
    for (int i = 0; i < 1024; i++) mem[i] = 32'hc0de_0000 ^ (i << 2);  // Never a legal opcode
    pc_idx = `CORE_RESET_ADDR >> 2;
    case (prog_sel)
      2'd0: load_main();
      2'd1: begin
        emit(addi(5'd1, 5'd0, 12'd1));
        emit(32'hffff_ffff);
      end
      2'd2: begin
        emit(addi(5'd1, 5'd0, 12'h400));
        emit(enc_i(12'h400, 5'd1, isa_pkg::F3_WORD, 5'd2, isa_pkg::OPC_LOAD));  // 0x800
      end
      default: begin
        emit(addi(5'd1, 5'd0, 12'h402));
        emit(enc_i(12'd0, 5'd1, isa_pkg::F3_WORD, 5'd2, isa_pkg::OPC_LOAD));
      end
    endcase
  endtask

  // Program reloaded as each reset releases
  always @(posedge rst_n) load_program();

  // Responses change 1 ns after the edge
  initial begin
    wb_rdata = 32'd0;
    wb_ack   = 1'b0;
    wb_err   = 1'b0;
    pending  = 1'b0;
    wait_cnt = 2'd0;
    void'($urandom(32'h078f_f1ea));  // Fixed wait-state sequence
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n || wb_ack || wb_err) begin
        wb_ack = 1'b0;
        wb_err = 1'b0;
        if (!rst_n) pending = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!pending) begin
          pending  = 1'b1;
          wait_cnt = 2'($urandom_range(3, 0));
        end
        if (wait_cnt != 2'd0) begin
          wait_cnt = wait_cnt - 2'd1;
        end else begin
          pending = 1'b0;
          if (wb_adr >= 32'h800 && wb_adr <= 32'h8ff) begin
            wb_err = 1'b1;  // Error window
          end else begin
            if (wb_we) begin
              for (int i = 0; i < 4; i++) begin
                if (wb_sel[i]) mem[wb_adr[11:2]][8*i +: 8] = wb_wdata[8*i +: 8];
              end
            end
            wb_rdata = mem[wb_adr[11:2]];
            wb_ack   = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== bench/tb_rv_mc_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for rv_mc_core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_rv_mc_core;

  localparam logic [31:0] RES_BASE   = 32'h400;
  localparam logic [31:0] FINAL_ADDR = 32'h444;
  localparam int          LOOP_N     = 5;

  logic        clk, rst_n;
  logic [1:0]  prog_sel;
  logic        wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [31:0] wb_adr, wb_wdata, wb_rdata, pc;
  logic [3:0]  wb_sel;
  logic        instr_retired, trap, trap_expected;
  ctrl_pkg::trap_cause_e trap_cause;
  logic [31:0] exp_val [0:17];
  logic        cyc_prev, cyc_seen, final_seen, misaligned_bus;
  int          retire_cnt, store_cnt, trap_starts, errors, timeouts, exp_retired;
  logic [31:0] a, b;

  clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  wb_memory_model mem_i (.*);

  rv_mc_core UUT (.*);

  task automatic report(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [31:0] expected_word(input logic [31:0] adr);
    return exp_val[(adr - RES_BASE) >> 2];
  endfunction

  // Bus and status bookkeeping cleared by every reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_prev <= 1'b0;
      cyc_seen <= 1'b0;
      final_seen <= 1'b0;
      misaligned_bus <= 1'b0;
      retire_cnt <= 0;
      store_cnt <= 0;
      trap_starts <= 0;
    end else begin
      cyc_prev <= wb_cyc;
      if (wb_cyc) cyc_seen <= 1'b1;
      if (instr_retired) retire_cnt <= retire_cnt + 1;
      if (wb_cyc && !cyc_prev && trap) trap_starts <= trap_starts + 1;
      if (wb_cyc && wb_adr[1:0] != 2'b00) misaligned_bus <= 1'b1;
      if (wb_cyc && wb_ack && wb_we && wb_adr >= RES_BASE && wb_adr <= FINAL_ADDR) begin
        store_cnt <= store_cnt + 1;
        if (wb_adr == FINAL_ADDR) final_seen <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && !cyc_seen) |-> wb_stb && !wb_we && wb_adr == `CORE_RESET_ADDR)
    else report("first bus cycle is not a read of the reset address");
  // Program area reads are instruction fetches from the PC
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && !wb_we && wb_adr < RES_BASE) |-> wb_adr == pc)
    else report($sformatf("fetch from %h while pc is %h", wb_adr, pc));
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && !wb_ack && !wb_err) |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
    else report("bus signals changed before ack or err");
  assert property (@(posedge clk) disable iff (!rst_n) wb_sel == 4'hf)
    else report("wb_sel not all ones");
  assert property (@(posedge clk) disable iff (!rst_n) !trap_expected |-> !trap)
    else report("unexpected trap");
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && wb_ack && wb_we && wb_adr >= RES_BASE && wb_adr <= FINAL_ADDR) |->
    wb_wdata == expected_word(wb_adr))
    else report($sformatf("wrong store to %h", wb_adr));
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && wb_ack && wb_we && wb_adr == FINAL_ADDR) |-> retire_cnt == exp_retired)
    else report($sformatf("retired %0d instructions, expected %0d", retire_cnt, exp_retired));

  task automatic wait_final_store();
    int n;
    for (n = 0; n < 5000 && !final_seen; n++) @(posedge clk);
    if (!final_seen) begin
      timeouts++;
      $display("Timeout: the final store of the main program never reached the bus");
    end
  endtask

  task automatic run_trap(input logic [1:0] sel, input ctrl_pkg::trap_cause_e cause);
    int n;
    prog_sel = sel;
    clk_gen_i.apply_reset();
    for (n = 0; n < 2000 && !trap; n++) @(posedge clk);
    if (!trap) begin
      timeouts++;
      $display("Timeout: trap never raised for program %0d", sel);
    end else begin
      assert (trap_cause == cause) else report($sformatf("trap cause %0d", trap_cause));
      repeat (20) @(posedge clk);
      assert (trap_starts == 0 && trap) else report("bus cycle or trap release after trap");
      assert (!misaligned_bus) else report("misaligned address reached the bus");
    end
  endtask

  initial begin
    errors = 0;
    timeouts = 0;
    prog_sel = 2'd0;
    trap_expected = 1'b0;
    a = 32'd100;
    b = -32'sd7;
    exp_val[0] = a;
    exp_val[1] = b;
    exp_val[2] = 32'h12345 << 12;
    exp_val[3] = 32'd16 + (32'd1 << 12);  // AUIPC at address 16
    exp_val[4] = b << 4;
    exp_val[5] = $signed(b) >>> 1;
    exp_val[6] = b >> 28;
    exp_val[7] = {31'd0, $signed(b) < $signed(a)};
    exp_val[8] = {31'd0, b < a};
    exp_val[9] = a ^ b;
    exp_val[10] = exp_val[2] | a;
    exp_val[11] = b & a;
    exp_val[12] = a - b;
    exp_val[13] = LOOP_N;
    exp_val[14] = 32'd4 * 35;  // Link of the JAL at word 34
    exp_val[15] = 32'd4 * 37;  // Link of the JALR at word 36
    exp_val[16] = (32'ha5a5a << 12) + 32'h5a5;
    exp_val[17] = exp_val[16];
    // Setup, ops, stores, loop, branches, jumps, link stores, LUI/ADDI/SW/LW
    exp_retired = 1 + 13 + 13 + 2 + 2 * LOOP_N + 2 + 2 + 3 + 4;
    clk_gen_i.apply_reset();
    assert (!wb_cyc && !wb_stb && !wb_we && !trap && !instr_retired)
      else report("outputs not idle after reset");
    wait_final_store();
    @(posedge clk);
    assert (store_cnt == 18) else report($sformatf("%0d result stores seen", store_cnt));
    trap_expected = 1'b1;
    run_trap(2'd1, ctrl_pkg::TRAP_ILLEGAL);
    run_trap(2'd2, ctrl_pkg::TRAP_BUS_ERR);
    run_trap(2'd3, ctrl_pkg::TRAP_MISALIGNED);
    $display("Errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/control_unit.sv
hdl/datapath_unit.sv
hdl/wb_bus_bridge.sv
hdl/rv_mc_core.sv
bench/clk_gen.sv
bench/wb_memory_model.sv
bench/tb_rv_mc_core.sv
